// ==== rtl/alu_imm_defs.svh ====
/*
    sizes for the register-immediate execution slice
    bank count is a power of two; a register's bank is its low index bits
    the LOG_ values are kept by hand and must match their counts
*/
`ifndef ALU_IMM_DEFS_SVH
`define ALU_IMM_DEFS_SVH

// physical registers
`define ALU_IMM_PR_COUNT          16
`define ALU_IMM_LOG_PR_COUNT      4

// PRF banking
`define ALU_IMM_PRF_BANKS         2
`define ALU_IMM_LOG_PRF_BANKS     1

// ROB index space
`define ALU_IMM_ROB_ENTRIES       16
`define ALU_IMM_LOG_ROB_ENTRIES   4

// issue queue depth and datapath width
`define ALU_IMM_IQ_ENTRIES        8
`define ALU_IMM_XLEN              32

`endif

// ==== rtl/alu_imm_pkg.sv ====
/*
    types shared by the queue, the PRF and the pipe
    op codes follow {funct7[5], funct3}; SRLI and SRAI share funct3 and the
    pipe picks the shift kind from the immediate's function field
*/
`include "alu_imm_defs.svh"

package alu_imm_pkg;

    typedef enum logic [3:0] {
        ALU_ADDI  = 4'b0000,
        ALU_SLLI  = 4'b0001,
        ALU_SLTI  = 4'b0010,
        ALU_SLTIU = 4'b0011,
        ALU_XORI  = 4'b0100,
        ALU_SRLI  = 4'b0101,
        ALU_ORI   = 4'b0110,
        ALU_ANDI  = 4'b0111,
        ALU_SRAI  = 4'b1101
    } alu_imm_op_e;

    // same 12 bits, read as a signed value or as a shift encoding
    typedef union packed {
        logic signed [11:0] simm;
        struct packed {
            logic [6:0] funct7;     // bit 5 set for arithmetic right shift
            logic [4:0] shamt;
        } sh;
    } alu_imm_u;

    typedef struct packed {
        alu_imm_op_e                          op;
        alu_imm_u                             imm;
        logic [`ALU_IMM_LOG_PR_COUNT-1:0]     a_pr;
        logic                                 a_ready;
        logic                                 a_is_zero;
        logic [`ALU_IMM_LOG_PR_COUNT-1:0]     dest_pr;
        logic [`ALU_IMM_LOG_ROB_ENTRIES-1:0]  rob_index;
    } iq_enq_t;

    typedef struct packed {
        alu_imm_op_e                          op;
        alu_imm_u                             imm;
        logic                                 a_is_reg;
        logic                                 a_is_bus_forward;
        logic                                 a_is_fast_forward;
        logic [`ALU_IMM_LOG_PR_COUNT-1:0]     a_pr;
        logic [`ALU_IMM_LOG_PR_COUNT-1:0]     dest_pr;
        logic [`ALU_IMM_LOG_ROB_ENTRIES-1:0]  rob_index;
    } iq_issue_t;

    typedef struct packed {
        logic                                 valid;
        logic [`ALU_IMM_LOG_PR_COUNT-1:0]     pr;
        logic [`ALU_IMM_XLEN-1:0]             data;
    } wb_port_t;

endpackage

// ==== rtl/pe_lsb.sv ====
/*
    lowest-index priority encoder
    ack_mask marks the granted bit and every bit above it; all zero when
    nothing is requested
*/
`timescale 1ns/10ps

module pe_lsb #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req_vec,
    output logic [WIDTH-1:0] ack_one_hot,
    output logic [WIDTH-1:0] ack_mask
);

    // running OR from bit 0 upward
    always_comb begin
        ack_mask[0] = req_vec[0];
        for (int i = 1; i < WIDTH; i++) begin
            ack_mask[i] = ack_mask[i-1] | req_vec[i];
        end
    end

    // first set bit of the mask is the grant
    assign ack_one_hot = ack_mask & ~(ack_mask << 1);

endmodule

// ==== rtl/alu_imm_iq.sv ====
/*
    collapsing issue queue for register-immediate ops, oldest entry at index 0
    one enqueue and one issue per cycle; issue has no back-pressure
    external bus port b must only carry registers of bank b
    an op matching the fast-forward notice issues straight off the execute result
*/
`timescale 1ns/10ps
`include "alu_imm_defs.svh"

module alu_imm_iq
    import alu_imm_pkg::*;
(
    input  logic                                 CLK,
    input  logic                                 nRST,

    // dispatch side
    input  logic                                 enq_valid,
    input  iq_enq_t                              enq,
    output logic                                 enq_ready,

    // wakeup sources
    input  wb_port_t [`ALU_IMM_PRF_BANKS-1:0]    wb_bus_in,
    input  wb_port_t                             fast_fwd,

    // to the pipe
    output logic                                 issue_valid,
    output iq_issue_t                            issue
);

    localparam int N  = `ALU_IMM_IQ_ENTRIES;
    localparam int LB = `ALU_IMM_LOG_PRF_BANKS;

    // ------------------------------------------------------------
    // entry state

    logic [N-1:0]       valid_q;
    iq_enq_t [N-1:0]    entry_q;

    logic [N-1:0]       bus_match;
    logic [N-1:0]       fast_match;
    logic [N-1:0]       ready_by_entry;
    logic [N-1:0]       issue_one_hot;
    logic [N-1:0]       issue_mask;
    logic [N-1:0]       free_one_hot;
    logic [N-1:0]       enq_slot;
    logic               enq_fire;
    logic               enq_wake;

    // one spare position on top so the collapse loop reads i+1 everywhere
    logic [N:0]         valid_ext;
    iq_enq_t [N:0]      entry_ext;
    logic [N:0]         wake_ext;
    logic [N:0]         slot_ext;

    logic [N-1:0]       valid_d;
    iq_enq_t [N-1:0]    entry_d;

    function automatic logic bus_hit(
        input logic [`ALU_IMM_LOG_PR_COUNT-1:0]     pr,
        input wb_port_t [`ALU_IMM_PRF_BANKS-1:0]    bus
    );
        logic [LB-1:0] bank;
        bank = pr[LB-1:0];
        return bus[bank].valid && (bus[bank].pr == pr);
    endfunction

    // ------------------------------------------------------------
    // wakeup and select

    always_comb begin
        for (int i = 0; i < N; i++) begin
            bus_match[i]  = bus_hit(entry_q[i].a_pr, wb_bus_in);
            fast_match[i] = fast_fwd.valid && (fast_fwd.pr == entry_q[i].a_pr);
            ready_by_entry[i] = valid_q[i] & (entry_q[i].a_ready | entry_q[i].a_is_zero
                                              | bus_match[i] | fast_match[i]);
        end
    end

    pe_lsb #(.WIDTH(N)) u_issue_pe (
        .req_vec     (ready_by_entry),
        .ack_one_hot (issue_one_hot),
        .ack_mask    (issue_mask)
    );

    assign issue_valid = |ready_by_entry;

    // one-hot mux, zero wins over any match on the register index
    always_comb begin
        issue = '0;
        for (int i = 0; i < N; i++) begin
            if (issue_one_hot[i]) begin
                issue.op                = entry_q[i].op;
                issue.imm               = entry_q[i].imm;
                issue.a_is_bus_forward  = ~entry_q[i].a_is_zero & bus_match[i];
                issue.a_is_fast_forward = ~entry_q[i].a_is_zero & ~bus_match[i]
                                          & fast_match[i];
                issue.a_is_reg          = ~entry_q[i].a_is_zero & ~bus_match[i]
                                          & ~fast_match[i];
                issue.a_pr              = entry_q[i].a_pr;
                issue.dest_pr           = entry_q[i].dest_pr;
                issue.rob_index         = entry_q[i].rob_index;
            end
        end
    end

    // ------------------------------------------------------------
    // enqueue into the lowest free slot

    pe_lsb #(.WIDTH(N)) u_free_pe (
        .req_vec     (~valid_q),
        .ack_one_hot (free_one_hot),
        .ack_mask    ()
    );

    assign enq_ready = ~&valid_q;
    assign enq_fire  = enq_valid & enq_ready;
    assign enq_slot  = free_one_hot & {N{enq_valid}};

    // a source written in the enqueue cycle must not be missed
    assign enq_wake  = bus_hit(enq.a_pr, wb_bus_in)
                       || (fast_fwd.valid && (fast_fwd.pr == enq.a_pr));

    // ------------------------------------------------------------
    // collapse: entries at and above the issued one take from above

    assign valid_ext = {1'b0, valid_q};
    assign entry_ext = {iq_enq_t'('0), entry_q};
    assign wake_ext  = {1'b0, bus_match | fast_match};
    assign slot_ext  = {1'b0, enq_slot};

    always_comb begin
        int src;
        for (int i = 0; i < N; i++) begin
            src = issue_mask[i] ? i + 1 : i;
            if (valid_ext[src]) begin
                valid_d[i]         = 1'b1;
                entry_d[i]         = entry_ext[src];
                entry_d[i].a_ready = entry_ext[src].a_ready | wake_ext[src];
            end else begin
                valid_d[i]         = slot_ext[src];
                entry_d[i]         = enq;
                entry_d[i].a_ready = enq.a_ready | enq_wake;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge CLK) begin
        entry_q <= entry_d;
    end

    // ------------------------------------------------------------
    // checks

    // an issued entry leaves the queue, so the next grant is another op
    a_issue_once: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |=> !(issue_valid && (issue.rob_index == $past(issue.rob_index))))
        else $error("entry issued in two consecutive cycles");

    // occupancy moves by accepted enqueues minus issues, so no enqueue while full
    a_occupancy: assert property (@(posedge CLK) disable iff (!nRST)
        nRST |=> $countones(valid_q) == $past($countones(valid_q))
                 + $past(int'(enq_fire)) - $past(int'(issue_valid)))
        else $error("entry lost, duplicated or enqueued while full");

endmodule

// ==== rtl/prf_banked.sv ====
/*
    banked physical register file, cleared to zero on reset
    external port b writes bank b only; the internal port goes by its low bit
    writing one register from both ports in a cycle is illegal
    read is combinational
*/
`timescale 1ns/10ps
`include "alu_imm_defs.svh"

module prf_banked
    import alu_imm_pkg::*;
(
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  wb_port_t [`ALU_IMM_PRF_BANKS-1:0]    ext_wr,
    input  wb_port_t                             int_wr,
    input  logic [`ALU_IMM_LOG_PR_COUNT-1:0]     rd_pr,
    output logic [`ALU_IMM_XLEN-1:0]             rd_data
);

    localparam int B     = `ALU_IMM_PRF_BANKS;
    localparam int LB    = `ALU_IMM_LOG_PRF_BANKS;
    localparam int LPR   = `ALU_IMM_LOG_PR_COUNT;
    localparam int DEPTH = `ALU_IMM_PR_COUNT / B;

    logic [`ALU_IMM_XLEN-1:0]  bank_q [B][DEPTH];
    logic [LB-1:0]             int_bank;

    assign int_bank = int_wr.pr[LB-1:0];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int b = 0; b < B; b++) begin
                for (int r = 0; r < DEPTH; r++) begin
                    bank_q[b][r] <= '0;
                end
            end
        end else begin
            for (int b = 0; b < B; b++) begin
                if (ext_wr[b].valid) begin
                    bank_q[b][ext_wr[b].pr[LPR-1:LB]] <= ext_wr[b].data;
                end
                // own result, steered by its bank bit
                if (int_wr.valid && (int_bank == LB'(b))) begin
                    bank_q[b][int_wr.pr[LPR-1:LB]] <= int_wr.data;
                end
            end
        end
    end

    assign rd_data = bank_q[rd_pr[LB-1:0]][rd_pr[LPR-1:LB]];

    // bus and pipe must never target the same register together
    a_no_double_write: assert property (@(posedge CLK) disable iff (!nRST)
        int_wr.valid |-> !(ext_wr[int_bank].valid && (ext_wr[int_bank].pr == int_wr.pr)))
        else $error("external and internal write to the same register");

endmodule

// ==== rtl/alu_imm_pipe.sv ====
/*
    two-stage register-immediate pipe: read/execute, then writeback register
    never stalls; an issued op reaches wb_out exactly two cycles later
    fast_fwd carries the execute-stage result, wb_out the one before it
*/
`timescale 1ns/10ps
`include "alu_imm_defs.svh"

module alu_imm_pipe
    import alu_imm_pkg::*;
(
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic                                 issue_valid,
    input  iq_issue_t                            issue,
    input  wb_port_t [`ALU_IMM_PRF_BANKS-1:0]    wb_bus_in,
    output logic [`ALU_IMM_LOG_PR_COUNT-1:0]     rd_pr,
    input  logic [`ALU_IMM_XLEN-1:0]             rd_data,
    output wb_port_t                             fast_fwd,
    output wb_port_t                             wb_out
);

    localparam int XLEN = `ALU_IMM_XLEN;
    localparam int LB   = `ALU_IMM_LOG_PRF_BANKS;

    logic                               ex_valid_q;
    iq_issue_t                          ex_q;
    logic [XLEN-1:0]                    bus_data_q;

    logic [XLEN-1:0]                    opnd_a;
    logic [XLEN-1:0]                    imm_ext;
    logic [4:0]                         shamt;
    logic                               shift_arith;
    logic [XLEN-1:0]                    result;

    logic                               wb_valid_q;
    logic [`ALU_IMM_LOG_PR_COUNT-1:0]   wb_pr_q;
    logic [XLEN-1:0]                    wb_data_q;

    // ------------------------------------------------------------
    // stage registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= issue_valid;
            wb_valid_q <= ex_valid_q;
        end
    end

    always_ff @(posedge CLK) begin
        ex_q <= issue;
        // bus value is only on the bus during the issue cycle
        if (issue_valid && issue.a_is_bus_forward) begin
            bus_data_q <= wb_bus_in[issue.a_pr[LB-1:0]].data;
        end
        if (ex_valid_q) begin
            wb_pr_q   <= ex_q.dest_pr;
            wb_data_q <= result;
        end
    end

    // ------------------------------------------------------------
    // operand A and execute

    assign rd_pr = ex_q.a_pr;

    always_comb begin
        if (ex_q.a_is_bus_forward) begin
            opnd_a = bus_data_q;
        end else if (ex_q.a_is_fast_forward) begin
            opnd_a = wb_data_q;
        end else if (ex_q.a_is_reg) begin
            opnd_a = rd_data;
        end else begin
            opnd_a = '0;
        end
    end

    assign imm_ext     = {{(XLEN-12){ex_q.imm.simm[11]}}, ex_q.imm.simm};
    assign shamt       = ex_q.imm.sh.shamt;
    assign shift_arith = ex_q.imm.sh.funct7[5];

    always_comb begin
        case (ex_q.op)
            ALU_ADDI:  result = opnd_a + imm_ext;
            ALU_SLTI:  result = {{(XLEN-1){1'b0}}, $signed(opnd_a) < $signed(imm_ext)};
            ALU_SLTIU: result = {{(XLEN-1){1'b0}}, opnd_a < imm_ext};
            ALU_XORI:  result = opnd_a ^ imm_ext;
            ALU_ORI:   result = opnd_a | imm_ext;
            ALU_ANDI:  result = opnd_a & imm_ext;
            ALU_SLLI:  result = opnd_a << shamt;
            // right shifts: kind comes from the function field
            ALU_SRLI, ALU_SRAI: begin
                if (shift_arith) begin
                    result = $unsigned($signed(opnd_a) >>> shamt);
                end else begin
                    result = opnd_a >> shamt;
                end
            end
            default:   result = '0;
        endcase
    end

    assign fast_fwd = '{valid: ex_valid_q, pr: ex_q.dest_pr, data: result};
    assign wb_out   = '{valid: wb_valid_q, pr: wb_pr_q, data: wb_data_q};

    // a fast-forwarded operand must be the writeback of A's register
    a_fast_fwd_source: assert property (@(posedge CLK) disable iff (!nRST)
        ex_valid_q && ex_q.a_is_fast_forward |-> wb_out.valid && (wb_out.pr == ex_q.a_pr))
        else $error("fast-forward operand is not the writeback of its source");

endmodule

// ==== rtl/alu_imm_subsys.sv ====
/*
    register-immediate execution slice: issue queue, banked PRF and pipe
    the external bus writes the PRF and wakes the queue in the same cycle
    wb_out is also the PRF's internal write
*/
`timescale 1ns/10ps
`include "alu_imm_defs.svh"

module alu_imm_subsys
    import alu_imm_pkg::*;
(
    input  logic                                 CLK,
    input  logic                                 nRST,

    // dispatch
    input  logic                                 enq_valid,
    input  iq_enq_t                              enq,
    output logic                                 enq_ready,

    // external writeback bus, one port per bank
    input  wb_port_t [`ALU_IMM_PRF_BANKS-1:0]    wb_bus_in,

    // this slice's results
    output wb_port_t                             wb_out
);

    logic                               issue_valid;
    iq_issue_t                          issue;
    wb_port_t                           fast_fwd;
    logic [`ALU_IMM_LOG_PR_COUNT-1:0]   rd_pr;
    logic [`ALU_IMM_XLEN-1:0]           rd_data;

    // ------------------------------------------------------------
    // queue

    alu_imm_iq u_iq (
        .CLK         (CLK),
        .nRST        (nRST),
        .enq_valid   (enq_valid),
        .enq         (enq),
        .enq_ready   (enq_ready),
        .wb_bus_in   (wb_bus_in),
        .fast_fwd    (fast_fwd),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    // ------------------------------------------------------------
    // register file and pipe

    prf_banked u_prf (
        .CLK     (CLK),
        .nRST    (nRST),
        .ext_wr  (wb_bus_in),
        .int_wr  (wb_out),
        .rd_pr   (rd_pr),
        .rd_data (rd_data)
    );

    alu_imm_pipe u_pipe (
        .CLK         (CLK),
        .nRST        (nRST),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb_bus_in   (wb_bus_in),
        .rd_pr       (rd_pr),
        .rd_data     (rd_data),
        .fast_fwd    (fast_fwd),
        .wb_out      (wb_out)
    );

endmodule

// ==== test/alu_imm_checker.sv ====
/*
    watches the slice's ports and checks each writeback against an ALU model
    writebacks are matched by destination register
    no two pending ops may share a destination
    a source must not be rewritten while an op that reads it is in flight
*/
`timescale 1ns/10ps
`include "alu_imm_defs.svh"

module alu_imm_checker
    import alu_imm_pkg::*;
(
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic                                 enq_valid,
    input  iq_enq_t                              enq,
    input  logic                                 enq_ready,
    input  wb_port_t [`ALU_IMM_PRF_BANKS-1:0]    wb_bus_in,
    input  wb_port_t                             wb_out,
    input  logic                                 expect_full,
    output int                                   pending_count,
    output int                                   err_count,
    output int                                   pass_count
);

    typedef struct packed {
        alu_imm_op_e                          op;
        logic [11:0]                          imm;
        logic [`ALU_IMM_LOG_PR_COUNT-1:0]     a_pr;
        logic                                 a_zero;
        logic [`ALU_IMM_LOG_PR_COUNT-1:0]     dest;
        logic [`ALU_IMM_LOG_ROB_ENTRIES-1:0]  rob;
        logic                                 src_ok;   // source written since enqueue
    } pending_op_t;

    pending_op_t               pend[$];
    logic [`ALU_IMM_XLEN-1:0]  shadow [`ALU_IMM_PR_COUNT];
    logic [`ALU_IMM_XLEN-1:0]  model_data;
    bit                        started;
    int                        test_no;

    initial begin
        err_count     = 0;
        pass_count    = 0;
        pending_count = 0;
        test_no       = 0;
        started       = 0;
    end

    // reference ALU, written from the instruction rules
    function automatic logic [31:0] expected_result(input alu_imm_op_e op,
                                                    input logic [11:0] imm,
                                                    input logic [31:0] a);
        logic [31:0]        s;
        logic signed [31:0] sa;
        s  = {{20{imm[11]}}, imm};
        sa = a;
        case (op)
            ALU_ADDI:  return a + s;
            ALU_SLTI:  return ($signed(a) < $signed(s)) ? 32'd1 : 32'd0;
            ALU_SLTIU: return (a < s) ? 32'd1 : 32'd0;
            ALU_XORI:  return a ^ s;
            ALU_ORI:   return a | s;
            ALU_ANDI:  return a & s;
            ALU_SLLI:  return a << imm[4:0];
            ALU_SRLI, ALU_SRAI: begin
                // imm bit 10 is funct7 bit 5
                if (imm[10]) begin
                    return sa >>> imm[4:0];
                end
                return a >> imm[4:0];
            end
            default:   return 32'd0;
        endcase
    endfunction

    // pending readers of a register see it written from this edge on
    task automatic mark_written(input logic [`ALU_IMM_LOG_PR_COUNT-1:0] pr);
        foreach (pend[i]) begin
            if (pend[i].a_pr == pr) begin
                pend[i].src_ok = 1'b1;
            end
        end
    endtask

    task automatic check_writeback();
        int          idx;
        bit          order_bad;
        pending_op_t r;
        logic [31:0] a;
        logic [31:0] exp;
        idx        = -1;
        order_bad  = 0;
        model_data = shadow[wb_out.pr];
        for (int i = 0; i < pend.size(); i++) begin
            if (idx < 0 && pend[i].dest == wb_out.pr) begin
                idx = i;
            end
        end
        test_no++;
        if (idx < 0) begin
            err_count++;
            $display("test %0d: writeback to register %0d with no pending op", test_no,
                     wb_out.pr);
            return;
        end
        r          = pend[idx];
        a          = r.a_zero ? 32'd0 : shadow[r.a_pr];
        exp        = expected_result(r.op, r.imm, a);
        model_data = exp;
        // ops on one source wake together and must leave oldest first
        for (int j = 0; j < idx; j++) begin
            if (!r.a_zero && !pend[j].a_zero && pend[j].a_pr == r.a_pr) begin
                order_bad = 1;
            end
        end
        if (!r.src_ok) begin
            err_count++;
            $display("test %0d: rob %0d wrote back before its source was written",
                     test_no, r.rob);
        end else if (order_bad) begin
            err_count++;
            $display("test %0d: rob %0d wrote back ahead of an older op on its source",
                     test_no, r.rob);
        end else if (wb_out.data !== exp) begin
            err_count++;
            $display("Fail test %0d rob %0d: wb_out.data expected %h got %h", test_no,
                     r.rob, exp, wb_out.data);
        end else begin
            pass_count++;
            $display("test %0d rob %0d: ok, pr %0d = %h", test_no, r.rob, r.dest, exp);
        end
        pend.delete(idx);
    endtask

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `ALU_IMM_PR_COUNT; i++) begin
                shadow[i] = '0;
            end
            pend.delete();
        end else begin
            if (wb_out.valid) begin
                check_writeback();
            end
            if (enq_valid && enq_ready) begin
                pend.push_back('{op: enq.op, imm: enq.imm, a_pr: enq.a_pr,
                                 a_zero: enq.a_is_zero, dest: enq.dest_pr,
                                 rob: enq.rob_index,
                                 src_ok: enq.a_ready | enq.a_is_zero});
                started = 1;
            end
            for (int b = 0; b < `ALU_IMM_PRF_BANKS; b++) begin
                if (wb_bus_in[b].valid) begin
                    shadow[wb_bus_in[b].pr] = wb_bus_in[b].data;
                    mark_written(wb_bus_in[b].pr);
                end
            end
            // the model's own result, so chained values do not follow the DUT
            if (wb_out.valid) begin
                shadow[wb_out.pr] = model_data;
                mark_written(wb_out.pr);
            end
        end
        pending_count = pend.size();
    end

    // idle state before the first enqueue, and the full-queue probe
    always @(negedge CLK) begin
        if (nRST && !started && (wb_out.valid || !enq_ready)) begin
            err_count++;
            $display("slice not idle before the first enqueue");
        end
        if (nRST && expect_full) begin
            test_no++;
            if (enq_ready) begin
                err_count++;
                $display("Fail test %0d: enq_ready expected %h got %h", test_no, 1'b0,
                         enq_ready);
            end else begin
                pass_count++;
                $display("test %0d: queue full, enq_ready low", test_no);
            end
        end
    end

    task automatic report();
        $display("checks passed %0d, failed %0d, pending %0d", pass_count, err_count,
                 pend.size());
    endtask

endmodule

// ==== test/alu_imm_tb.sv ====
/*
    testbench for the register-immediate slice
    rows of the stimulus table run one per clock; an enqueue row holds until accepted
    bus writes go to the port of the register's bank
*/
`timescale 1ns/10ps
`include "alu_imm_defs.svh"

module alu_imm_tb
    import alu_imm_pkg::*;
();

    localparam int MAX_ROWS = 96;
    localparam logic [1:0] ROW_IDLE = 2'd0;
    localparam logic [1:0] ROW_BUS  = 2'd1;
    localparam logic [1:0] ROW_ENQ  = 2'd2;
    localparam logic [1:0] ROW_FULL = 2'd3;

    typedef struct packed {
        logic [1:0]   kind;
        alu_imm_op_e  op;
        logic [11:0]  imm;
        logic [3:0]   a_pr;
        logic         ready;
        logic         zero;
        logic [3:0]   dest;
        logic [3:0]   rob;
        logic [31:0]  data;
    } row_t;

    logic                                CLK;
    logic                                nRST;
    logic                                enq_valid;
    iq_enq_t                             enq;
    logic                                enq_ready;
    wb_port_t [`ALU_IMM_PRF_BANKS-1:0]   wb_bus_in;
    wb_port_t                            wb_out;
    logic                                expect_full;
    int                                  pending_count;
    int                                  err_count;
    int                                  pass_count;

    row_t         rows [MAX_ROWS];
    int           row_count;
    int           rob_next;
    int           cycles;
    logic [31:0]  rng_state;

    alu_imm_subsys DUT (
        .CLK       (CLK),
        .nRST      (nRST),
        .enq_valid (enq_valid),
        .enq       (enq),
        .enq_ready (enq_ready),
        .wb_bus_in (wb_bus_in),
        .wb_out    (wb_out)
    );

    alu_imm_checker u_chk (
        .CLK           (CLK),
        .nRST          (nRST),
        .enq_valid     (enq_valid),
        .enq           (enq),
        .enq_ready     (enq_ready),
        .wb_bus_in     (wb_bus_in),
        .wb_out        (wb_out),
        .expect_full   (expect_full),
        .pending_count (pending_count),
        .err_count     (err_count),
        .pass_count    (pass_count)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ------------------------------------------------------------
    // table building

    task automatic add_row(input row_t r);
        rows[row_count] = r;
        row_count++;
    endtask

    task automatic add_idle(input int n);
        repeat (n) add_row('{kind: ROW_IDLE, op: ALU_ADDI, default: '0});
    endtask

    task automatic add_bus(input logic [3:0] pr, input logic [31:0] data);
        add_row('{kind: ROW_BUS, op: ALU_ADDI, a_pr: pr, data: data, default: '0});
    endtask

    task automatic add_enq(input alu_imm_op_e op, input logic [11:0] imm,
                           input logic [3:0] a_pr, input logic ready,
                           input logic zero, input logic [3:0] dest);
        add_row('{kind: ROW_ENQ, op: op, imm: imm, a_pr: a_pr, ready: ready, zero: zero,
                  dest: dest, rob: 4'(rob_next), data: '0});
        rob_next++;
    endtask

    task automatic build_table();
        add_idle(3);
        // sources; r5 negative for the signed ops
        add_bus(4'd2, next_rand());
        add_bus(4'd3, next_rand());
        add_bus(4'd5, next_rand() | 32'h8000_0000);
        add_bus(4'd6, next_rand());
        add_idle(2);
        // each op on ready sources
        add_enq(ALU_ADDI,  12'hffb, 4'd2, 1, 0, 4'd8);
        add_enq(ALU_SLTI,  12'hfff, 4'd5, 1, 0, 4'd9);
        add_enq(ALU_SLTIU, 12'hfff, 4'd2, 1, 0, 4'd10);
        add_enq(ALU_XORI,  12'h5a5, 4'd3, 1, 0, 4'd11);
        add_enq(ALU_ORI,   12'h0f0, 4'd3, 1, 0, 4'd12);
        add_enq(ALU_ANDI,  12'h7ff, 4'd5, 1, 0, 4'd13);
        add_enq(ALU_SLLI,  12'h007, 4'd2, 1, 0, 4'd14);
        add_enq(ALU_SRLI,  12'h01f, 4'd5, 1, 0, 4'd15);
        add_enq(ALU_SRAI,  12'h40c, 4'd5, 1, 0, 4'd7);
        // zero source ignores r3
        add_enq(ALU_ADDI,  12'h123, 4'd3, 0, 1, 4'd1);
        add_idle(6);
        // waits for the bus write to r6
        add_enq(ALU_ADDI,  12'h007, 4'd6, 0, 0, 4'd0);
        add_idle(5);
        add_bus(4'd6, next_rand());
        add_idle(4);
        // dependent chain, back to back
        add_enq(ALU_ADDI,  12'h001, 4'd2, 1, 0, 4'd4);
        add_enq(ALU_XORI,  12'h8a3, 4'd4, 0, 0, 4'd6);
        add_enq(ALU_SLLI,  12'h003, 4'd6, 0, 0, 4'd9);
        add_enq(ALU_ADDI,  12'hf9c, 4'd9, 0, 0, 4'd11);
        add_idle(6);
        // fill the queue on one source
        add_enq(ALU_ADDI,  12'h010, 4'd12, 0, 0, 4'd0);
        add_enq(ALU_XORI,  12'hfff, 4'd12, 0, 0, 4'd1);
        add_enq(ALU_SRAI,  12'h404, 4'd12, 0, 0, 4'd3);
        add_enq(ALU_SRLI,  12'h004, 4'd12, 0, 0, 4'd5);
        add_enq(ALU_ORI,   12'h800, 4'd12, 0, 0, 4'd7);
        add_enq(ALU_ANDI,  12'h0ff, 4'd12, 0, 0, 4'd8);
        add_enq(ALU_SLTI,  12'h000, 4'd12, 0, 0, 4'd10);
        add_enq(ALU_SLTIU, 12'h7ff, 4'd12, 0, 0, 4'd14);
        add_row('{kind: ROW_FULL, op: ALU_ADDI, default: '0});
        add_idle(2);
        add_bus(4'd12, next_rand());
        add_idle(14);
    endtask

    // ------------------------------------------------------------
    // row driver

    task automatic apply_row(input row_t r);
        @(posedge CLK);
        enq_valid   <= 1'b0;
        expect_full <= 1'b0;
        for (int b = 0; b < `ALU_IMM_PRF_BANKS; b++) begin
            wb_bus_in[b].valid <= 1'b0;
        end
        case (r.kind)
            ROW_BUS: begin
                wb_bus_in[r.a_pr[0]] <= '{valid: 1'b1, pr: r.a_pr, data: r.data};
            end
            ROW_ENQ: begin
                enq_valid <= 1'b1;
                enq       <= '{op: r.op, imm: alu_imm_u'(r.imm), a_pr: r.a_pr,
                               a_ready: r.ready, a_is_zero: r.zero, dest_pr: r.dest,
                               rob_index: r.rob};
                // held until an edge sees enq_ready high
                @(negedge CLK);
                while (!enq_ready) begin
                    @(negedge CLK);
                end
            end
            ROW_FULL: begin
                expect_full <= 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // run limit scales with the table
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (row_count > 0 && cycles >= row_count * 20) begin
            $display("run stopped after %0d cycles with %0d ops pending", cycles,
                     pending_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        nRST        = 1'b0;
        enq_valid   = 1'b0;
        enq         = '0;
        wb_bus_in   = '0;
        expect_full = 1'b0;
        cycles      = 0;
        row_count   = 0;
        rob_next    = 0;
        rng_state   = 32'd79093;
        build_table();
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        for (int i = 0; i < row_count; i++) begin
            apply_row(rows[i]);
        end
        apply_row('{kind: ROW_IDLE, op: ALU_ADDI, default: '0});
        while (pending_count != 0) begin
            @(negedge CLK);
        end
        repeat (2) @(posedge CLK);
        u_chk.report();
        if (err_count == 0 && pass_count > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/alu_imm_pkg.sv
rtl/pe_lsb.sv
rtl/alu_imm_iq.sv
rtl/prf_banked.sv
rtl/alu_imm_pipe.sv
rtl/alu_imm_subsys.sv
test/alu_imm_checker.sv
test/alu_imm_tb.sv
